/* src.f */
+incdir+include
design/cpu_pkg.sv
design/controller.sv
design/fetch_unit.sv
design/regfile.sv
design/imm_select.sv
design/alu.sv
design/cpu_core.sv
verification/cpu_core_tb.sv

/* Makefile */
# Verilator build and run for the multi-cycle processor core

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := cpu_core_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
PASS_TEXT := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* verification/cpu_core_tb.sv */
// testbench for the processor core with random program and ISA reference model
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core_tb;

  import cpu_pkg::*;

  localparam int CLOCK_PERIOD = 4;
  localparam int NUM_INSTR    = 200;
  localparam int TIMEOUT_NS   = NUM_INSTR * 4 * CLOCK_PERIOD + 200;
  localparam word_t NOP_WORD  = {1'b0, OP_ALU, 20'b0, SUB_SRLI};

  logic      clock;
  logic      reset;
  word_t     instr_data;
  word_t     instr_address;
  logic      wb_valid;
  reg_addr_t wb_address;
  word_t     wb_data;

  word_t program_mem [NUM_INSTR];
  word_t model_regs [`REG_COUNT];
  word_t model_pc;
  int    cycles;
  int    writebacks;
  int    errors;

  cpu_core cpu_core_inst (
    .clock         (clock),
    .reset         (reset),
    .instr_data    (instr_data),
    .instr_address (instr_address),
    .wb_valid      (wb_valid),
    .wb_address    (wb_address),
    .wb_data       (wb_data)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  function automatic opcode_t unknown_opcode();
    opcode_t op;
    do begin
      op = opcode_t'($urandom);
    end while (op inside {OP_ALU, OP_ADDI, OP_ORI, OP_XORI, OP_MOVI});
    return op;
  endfunction

  function automatic sub_opcode_t pick_sub_opcode();
    sub_opcode_t sub;
    case ($urandom_range(9, 0))
      0: sub = SUB_ADD;
      1: sub = SUB_SUB;
      2: sub = SUB_AND;
      3: sub = SUB_XOR;
      4: sub = SUB_OR;
      5: sub = SUB_SLLI;
      6: sub = SUB_SRLI;
      7: sub = SUB_ROTRI;
      // anything, mostly undefined codes
      default: sub = sub_opcode_t'($urandom);
    endcase
    return sub;
  endfunction

  task automatic build_program();
    int    kind;
    word_t instr;
    for (int i = 0; i < NUM_INSTR; i++) begin
      kind  = $urandom_range(9, 0);
      instr = $urandom;
      case (kind)
        4: instr[30:25] = OP_ADDI;
        5: instr[30:25] = OP_ORI;
        6: instr[30:25] = OP_XORI;
        7: instr[30:25] = OP_MOVI;
        8: instr[30:25] = unknown_opcode();
        default: instr[30:25] = OP_ALU;
      endcase
      if (kind <= 3 || kind == 8) begin
        instr[4:0] = pick_sub_opcode();
      end
      if (kind == 9) begin
        instr = NOP_WORD;
      end
      program_mem[i] = instr;
    end
  endtask

  function automatic word_t fetch_word(input word_t address);
    int index;
    index = int'(address >> 2);
    if (index < NUM_INSTR) begin
      return program_mem[index];
    end
    return NOP_WORD;
  endfunction

  // reference ISA semantics on the model registers
  function automatic word_t expected_result(input word_t instr);
    word_t      a;
    word_t      b;
    word_t      r;
    logic [4:0] sh;
    a  = model_regs[instr[19:15]];
    b  = model_regs[instr[14:10]];
    // only the alu group shifts by the immediate
    sh = (instr[30:25] == OP_ALU) ? instr[14:10] : b[4:0];
    case (instr[30:25])
      OP_ADDI: r = a + {{17{instr[14]}}, instr[14:0]};
      OP_ORI:  r = a | {17'b0, instr[14:0]};
      OP_XORI: r = a ^ {17'b0, instr[14:0]};
      OP_MOVI: r = {{12{instr[19]}}, instr[19:0]};
      default: begin
        case (instr[4:0])
          SUB_ADD:   r = a + b;
          SUB_SUB:   r = a - b;
          SUB_AND:   r = a & b;
          SUB_OR:    r = a | b;
          SUB_XOR:   r = a ^ b;
          SUB_SLLI:  r = a << sh;
          SUB_SRLI:  r = a >> sh;
          SUB_ROTRI: r = (sh == 0) ? a : ((a >> sh) | (a << (32 - sh)));
          default:   r = '0;
        endcase
      end
    endcase
    return r;
  endfunction

  task automatic clear_model();
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    model_pc   = '0;
    cycles     = 0;
    writebacks = 0;
  endtask

  // instruction memory answers from the current address
  always @(posedge clock) begin
    #1;
    instr_data = fetch_word(instr_address);
  end

  always @(negedge clock) begin : check_block
    word_t instr;
    word_t expected;
    if (reset) begin
      assert (wb_valid == 1'b0) else begin
        errors++;
        $display("Fail %0t wb_valid expected 0 actual %b", $time, wb_valid);
      end
      clear_model();
    end else begin
      cycles++;
      // strobe in every 4th cycle after release
      assert (wb_valid == (cycles % 4 == 0)) else begin
        errors++;
        $display("Fail %0t wb_valid expected %b actual %b", $time,
                 (cycles % 4 == 0), wb_valid);
      end
      assert (instr_address == model_pc) else begin
        errors++;
        $display("Fail %0t instr_address expected %h actual %h", $time,
                 model_pc, instr_address);
      end
      if (wb_valid && writebacks < NUM_INSTR) begin
        instr    = program_mem[model_pc >> 2];
        expected = expected_result(instr);
        assert (wb_address == instr[24:20]) else begin
          errors++;
          $display("Fail %0t wb_address expected %0d actual %0d", $time,
                   instr[24:20], wb_address);
        end
        assert (wb_data == expected) else begin
          errors++;
          $display("Fail %0t wb_data expected %h actual %h", $time, expected, wb_data);
        end
        model_regs[instr[24:20]] = expected;
        model_pc   = model_pc + word_t'(`PC_STEP);
        writebacks++;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: only %0d of %0d instructions were written back", writebacks,
             NUM_INSTR);
    $display("errors: %0d", errors);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    reset      = 1'b1;
    instr_data = '0;
    errors     = 0;
    void'($urandom(32'h61f2e98e));
    build_program();
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    wait (writebacks == NUM_INSTR);
    repeat (2) @(posedge clock);
    $display("writebacks: %0d, errors: %0d", writebacks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/cpu_core.sv */
// multi-cycle processor core top with instruction and writeback ports
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
  input  wire                   clock,
  input  wire                   reset,
  input  wire cpu_pkg::word_t   instr_data,
  output cpu_pkg::word_t        instr_address,
  output logic                  wb_valid,
  output cpu_pkg::reg_addr_t    wb_address,
  output cpu_pkg::word_t        wb_data
);

  import cpu_pkg::*;

  logic      enable_fetch;
  logic      enable_execute;
  logic      enable_writeback;
  imm_sel_t  imm_sel;
  logic      imm_reg_select;
  logic      writeback_select;
  word_t     pc;
  word_t     ir;
  reg_addr_t read_address1;
  reg_addr_t read_address2;
  reg_addr_t write_address;
  word_t     read_data1;
  word_t     read_data2;
  word_t     operand2;
  word_t     imm_value;
  word_t     alu_result;
  word_t     write_data;

  // register fields of the instruction
  assign write_address = ir[24:20];
  assign read_address1 = ir[19:15];
  assign read_address2 = ir[14:10];

  controller controller_inst (
    .clock            (clock),
    .reset            (reset),
    .ir               (ir),
    .enable_fetch     (enable_fetch),
    .enable_execute   (enable_execute),
    .enable_writeback (enable_writeback),
    .imm_sel          (imm_sel),
    .imm_reg_select   (imm_reg_select),
    .writeback_select (writeback_select)
  );

  fetch_unit fetch_unit_inst (
    .clock            (clock),
    .reset            (reset),
    .enable_fetch     (enable_fetch),
    .enable_writeback (enable_writeback),
    .instr_data       (instr_data),
    .pc               (pc),
    .ir               (ir)
  );

  regfile regfile_inst (
    .clock         (clock),
    .reset         (reset),
    .read_address1 (read_address1),
    .read_address2 (read_address2),
    .write_address (write_address),
    .write_enable  (enable_writeback),
    .write_data    (write_data),
    .read_data1    (read_data1),
    .read_data2    (read_data2)
  );

  imm_select imm_select_inst (
    .ir             (ir),
    .imm_sel        (imm_sel),
    .imm_reg_select (imm_reg_select),
    .read_data2     (read_data2),
    .imm_value      (imm_value),
    .operand2       (operand2)
  );

  alu alu_inst (
    .clock          (clock),
    .reset          (reset),
    .enable_execute (enable_execute),
    .ir             (ir),
    .operand1       (read_data1),
    .operand2       (operand2),
    .alu_result     (alu_result)
  );

  // movi bypasses the alu
  assign write_data = writeback_select ? imm_value : alu_result;

  assign instr_address = pc;
  assign wb_valid      = enable_writeback;
  assign wb_address    = write_address;
  assign wb_data       = write_data;

endmodule

`default_nettype wire

/* design/alu.sv */
// opcode and sub-opcode decode with a result register loaded in execute
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   enable_execute,
  input  wire cpu_pkg::word_t   ir,
  input  wire cpu_pkg::word_t   operand1,
  input  wire cpu_pkg::word_t   operand2,
  output cpu_pkg::word_t        alu_result
);

  import cpu_pkg::*;

  opcode_t                      opcode;
  sub_opcode_t                  sub_opcode;
  logic [4:0]                   shift_amount;
  logic [2*$bits(word_t)-1:0]   rotate_pair;
  word_t                        result_next;

  assign opcode       = ir[30:25];
  assign sub_opcode   = ir[4:0];
  assign shift_amount = operand2[4:0];

  // doubled word so a right shift wraps the low bits around
  assign rotate_pair = {operand1, operand1} >> shift_amount;

  always_comb begin
    case (opcode)
      OP_ADDI: result_next = operand1 + operand2;
      OP_ORI:  result_next = operand1 | operand2;
      OP_XORI: result_next = operand1 ^ operand2;
      default: begin
        case (sub_opcode)
          SUB_ADD:   result_next = operand1 + operand2;
          SUB_SUB:   result_next = operand1 - operand2;
          SUB_AND:   result_next = operand1 & operand2;
          SUB_OR:    result_next = operand1 | operand2;
          SUB_XOR:   result_next = operand1 ^ operand2;
          SUB_SLLI:  result_next = operand1 << shift_amount;
          SUB_SRLI:  result_next = operand1 >> shift_amount;
          SUB_ROTRI: result_next = rotate_pair[$bits(word_t)-1:0];
          default:   result_next = '0;
        endcase
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_result <= '0;
    end else if (enable_execute) begin
      alu_result <= result_next;
    end
  end

endmodule

`default_nettype wire

/* design/imm_select.sv */
// immediate extraction and second operand mux
`timescale 1ns/10ps
`default_nettype none

module imm_select (
  input  wire cpu_pkg::word_t      ir,
  input  wire cpu_pkg::imm_sel_t   imm_sel,
  input  wire                      imm_reg_select,
  input  wire cpu_pkg::word_t      read_data2,
  output cpu_pkg::word_t           imm_value,
  output cpu_pkg::word_t           operand2
);

  import cpu_pkg::*;

  word_t imm5_ze;
  word_t imm15_se;
  word_t imm15_ze;
  word_t imm20_se;

  // shift amount shares the rs2 field
  assign imm5_ze  = {27'b0, ir[14:10]};
  assign imm15_se = {{17{ir[14]}}, ir[14:0]};
  assign imm15_ze = {17'b0, ir[14:0]};
  assign imm20_se = {{12{ir[19]}}, ir[19:0]};

  always_comb begin
    case (imm_sel)
      IMM15_SE: imm_value = imm15_se;
      IMM15_ZE: imm_value = imm15_ze;
      IMM20_SE: imm_value = imm20_se;
      default:  imm_value = imm5_ze;
    endcase
  end

  assign operand2 = imm_reg_select ? imm_value : read_data2;

endmodule

`default_nettype wire

/* design/regfile.sv */
// general register file with two read ports and one write port
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module regfile (
  input  wire                     clock,
  input  wire                     reset,
  input  wire cpu_pkg::reg_addr_t read_address1,
  input  wire cpu_pkg::reg_addr_t read_address2,
  input  wire cpu_pkg::reg_addr_t write_address,
  input  wire                     write_enable,
  input  wire cpu_pkg::word_t     write_data,
  output cpu_pkg::word_t          read_data1,
  output cpu_pkg::word_t          read_data2
);

  import cpu_pkg::*;

  word_t regs [`REG_COUNT];

  // r0 is writable like any other entry
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable) begin
      regs[write_address] <= write_data;
    end
  end

  assign read_data1 = regs[read_address1];
  assign read_data2 = regs[read_address2];

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
// program counter and instruction register of the core
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module fetch_unit (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   enable_fetch,
  input  wire                   enable_writeback,
  input  wire cpu_pkg::word_t   instr_data,
  output cpu_pkg::word_t        pc,
  output cpu_pkg::word_t        ir
);

  import cpu_pkg::*;

  localparam word_t PC_INCREMENT = word_t'(`PC_STEP);

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
      ir <= '0;
    end else begin
      // memory answers within the fetch cycle
      if (enable_fetch) begin
        ir <= instr_data;
      end
      // next instruction once the result is written
      if (enable_writeback) begin
        pc <= pc + PC_INCREMENT;
      end
    end
  end

endmodule

`default_nettype wire

/* design/controller.sv */
// four-state sequencer with operand and writeback source decode
`timescale 1ns/10ps
`default_nettype none

module controller (
  input  wire                   clock,
  input  wire                   reset,
  input  wire cpu_pkg::word_t   ir,
  output logic                  enable_fetch,
  output logic                  enable_execute,
  output logic                  enable_writeback,
  output cpu_pkg::imm_sel_t     imm_sel,
  output logic                  imm_reg_select,
  output logic                  writeback_select
);

  import cpu_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  opcode_t     opcode;
  sub_opcode_t sub_opcode;

  assign opcode     = ir[30:25];
  assign sub_opcode = ir[4:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= STOP_STATE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    case (state)
      STOP_STATE:  state_next = FETCH_STATE;
      FETCH_STATE: state_next = EXE_STATE;
      EXE_STATE:   state_next = WRITE_STATE;
      default:     state_next = STOP_STATE;
    endcase
  end

  // one enable per active state, none in stop
  assign enable_fetch     = (state == FETCH_STATE);
  assign enable_execute   = (state == EXE_STATE);
  assign enable_writeback = (state == WRITE_STATE);

  // imm_reg_select high picks the immediate as operand2
  // writeback_select high writes the immediate itself
  always_comb begin
    imm_sel          = IMM5_ZE;
    imm_reg_select   = 1'b0;
    writeback_select = 1'b0;
    case (opcode)
      OP_ALU: begin
        if (sub_opcode == SUB_SRLI || sub_opcode == SUB_SLLI ||
            sub_opcode == SUB_ROTRI) begin
          imm_reg_select = 1'b1;
        end
      end
      OP_ADDI: begin
        imm_sel        = IMM15_SE;
        imm_reg_select = 1'b1;
      end
      OP_ORI, OP_XORI: begin
        imm_sel        = IMM15_ZE;
        imm_reg_select = 1'b1;
      end
      OP_MOVI: begin
        imm_sel          = IMM20_SE;
        imm_reg_select   = 1'b1;
        writeback_select = 1'b1;
      end
      // unknown ops run as register alu ops
      default: begin
        imm_sel = IMM5_ZE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
// types and encodings of the multi-cycle processor core
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`DATA_SIZE-1:0] word_t;
  typedef logic [`ADDR_SIZE-1:0] reg_addr_t;
  typedef logic [5:0] opcode_t;
  typedef logic [4:0] sub_opcode_t;
  typedef logic [1:0] imm_sel_t;

  // controller sequence, one instruction per pass
  typedef enum logic [1:0] {
    STOP_STATE,
    FETCH_STATE,
    EXE_STATE,
    WRITE_STATE
  } ctrl_state_t;

  // immediate forms
  localparam imm_sel_t IMM5_ZE  = 2'd0;
  localparam imm_sel_t IMM15_SE = 2'd1;
  localparam imm_sel_t IMM15_ZE = 2'd2;
  localparam imm_sel_t IMM20_SE = 2'd3;

  // major opcodes, ir[30:25]
  localparam opcode_t OP_ALU  = 6'b100000;
  localparam opcode_t OP_ADDI = 6'b101000;
  localparam opcode_t OP_ORI  = 6'b101100;
  localparam opcode_t OP_XORI = 6'b101011;
  localparam opcode_t OP_MOVI = 6'b100010;

  // alu sub-opcodes, ir[4:0]
  localparam sub_opcode_t SUB_ADD   = 5'b00000;
  localparam sub_opcode_t SUB_SUB   = 5'b00001;
  localparam sub_opcode_t SUB_AND   = 5'b00010;
  localparam sub_opcode_t SUB_XOR   = 5'b00011;
  localparam sub_opcode_t SUB_OR    = 5'b00100;
  localparam sub_opcode_t SUB_SLLI  = 5'b01000;
  localparam sub_opcode_t SUB_SRLI  = 5'b01001;
  localparam sub_opcode_t SUB_ROTRI = 5'b01011;

endpackage

`default_nettype wire

/* include/cpu_cfg.svh */
// size settings shared by the processor core and its testbench
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and instruction word width
`define DATA_SIZE 32

// register number width
`define ADDR_SIZE 5

// entries in the register file
`define REG_COUNT 32

// byte increment of the program counter per instruction
`define PC_STEP 4

`endif
